// ==== Makefile ====
# Verilator build and run for the leaf_i5o2 testbench

VERILATOR ?= verilator
TOP       ?= tb_leaf_i5o2
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^=== PASS ===$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
+incdir+common
common/leaf_pkt_pkg.sv
common/leaf_cfg_pkg.sv
hw/leaf_interface/stream_fifo.sv
hw/leaf_interface/packet_dispatch.sv
hw/leaf_interface/packet_builder.sv
hw/leaf_interface/leaf_interface.sv
hw/leaf_user/user_kernel.sv
hw/leaf_i5o2.sv
sim/tb_leaf_i5o2.sv

// ==== common/leaf_cfg_pkg.sv ====
`default_nettype none
`include "leaf_macros.svh"

package leaf_cfg_pkg;

    import leaf_pkt_pkg::*;

    typedef struct packed {
        leaf_addr_t dest_leaf;
        port_addr_t dest_port;
    } route_entry_t;

    // entry 0 serves output 1
    typedef route_entry_t [`LEAF_NUM_OUT_PORTS-1:0] route_table_t;

    typedef struct packed {
        logic [11:0] rsvd_hi;
        port_addr_t  dest_port;
        logic [2:0]  rsvd_mid;
        leaf_addr_t  dest_leaf;
        logic [6:0]  rsvd_lo;
        logic        out_sel;
    } cfg_word_t;

    function automatic route_entry_t cfg_route(cfg_word_t cfg);
        route_entry_t entry;
        entry.dest_leaf = cfg.dest_leaf;
        entry.dest_port = cfg.dest_port;
        return entry;
    endfunction

endpackage

`default_nettype wire

// ==== common/leaf_macros.svh ====
`ifndef LEAF_MACROS_SVH
`define LEAF_MACROS_SVH

// network packet layout
`define LEAF_PACKET_BITS   49
`define LEAF_PAYLOAD_BITS  32
`define LEAF_LEAF_BITS     5
`define LEAF_PORT_BITS     4

// source port gets whatever the other fields leave over
`define LEAF_SRC_BITS \
    (`LEAF_PACKET_BITS - 1 - 2 * `LEAF_LEAF_BITS - `LEAF_PORT_BITS - `LEAF_PAYLOAD_BITS)

// user stream lanes
`define LEAF_NUM_IN_PORTS  5
`define LEAF_NUM_OUT_PORTS 2

`define LEAF_FIFO_DEPTH    8

// address this leaf answers to out of reset
`define LEAF_SELF_ADDR     5'd3

`endif

// ==== common/leaf_pkt_pkg.sv ====
`default_nettype none
`include "leaf_macros.svh"

package leaf_pkt_pkg;

    typedef logic [`LEAF_PAYLOAD_BITS-1:0] payload_t;
    typedef logic [`LEAF_LEAF_BITS-1:0]    leaf_addr_t;
    typedef logic [`LEAF_PORT_BITS-1:0]    port_addr_t;
    typedef logic [`LEAF_SRC_BITS-1:0]     src_port_t;

    // valid sits in the top bit
    typedef struct packed {
        logic       valid;
        leaf_addr_t dest_leaf;
        port_addr_t dest_port;
        leaf_addr_t src_leaf;
        src_port_t  src_port;
        payload_t   payload;
    } leaf_packet_t;

    function automatic logic pkt_for_leaf(leaf_packet_t pkt, leaf_addr_t addr);
        return pkt.valid && (pkt.dest_leaf == addr);
    endfunction

    function automatic leaf_packet_t make_packet(leaf_addr_t dest_leaf,
                                                 port_addr_t dest_port,
                                                 leaf_addr_t src_leaf,
                                                 src_port_t  src_port,
                                                 payload_t   payload);
        leaf_packet_t pkt;
        pkt.valid     = 1'b1;
        pkt.dest_leaf = dest_leaf;
        pkt.dest_port = dest_port;
        pkt.src_leaf  = src_leaf;
        pkt.src_port  = src_port;
        pkt.payload   = payload;
        return pkt;
    endfunction

endpackage

`default_nettype wire

// ==== hw/leaf_i5o2.sv ====
`default_nettype none
`include "leaf_macros.svh"

module leaf_i5o2
    import leaf_pkt_pkg::*;
(
    input  wire               clk_400,
    input  wire               arst_n,
    input  wire leaf_packet_t din_leaf_bft2interface,
    output wire leaf_packet_t dout_leaf_interface2bft,
    input  wire               resend,
    input  wire               ap_start
);

    // lane 0 carries port 1
    wire payload_t [`LEAF_NUM_IN_PORTS-1:0]  dout_leaf_interface2user;
    wire [`LEAF_NUM_IN_PORTS-1:0]            vld_interface2user;
    wire [`LEAF_NUM_IN_PORTS-1:0]            ack_user2interface;

    wire payload_t [`LEAF_NUM_OUT_PORTS-1:0] din_leaf_user2interface;
    wire [`LEAF_NUM_OUT_PORTS-1:0]           vld_user2interface;
    wire [`LEAF_NUM_OUT_PORTS-1:0]           ack_interface2user;

    wire                                     reset_ap_start_user;

    leaf_interface leaf_interface_inst (
        .clk_400                  (clk_400),
        .arst_n                   (arst_n),
        .din_leaf_bft2interface   (din_leaf_bft2interface),
        .dout_leaf_interface2bft  (dout_leaf_interface2bft),
        .resend                   (resend),
        .ap_start                 (ap_start),
        .dout_leaf_interface2user (dout_leaf_interface2user),
        .vld_interface2user       (vld_interface2user),
        .ack_user2interface       (ack_user2interface),
        .din_leaf_user2interface  (din_leaf_user2interface),
        .vld_user2interface       (vld_user2interface),
        .ack_interface2user       (ack_interface2user),
        .reset_ap_start_user      (reset_ap_start_user)
    );

    user_kernel user_kernel_inst (
        .clk_400                  (clk_400),
        .reset_ap_start_user      (reset_ap_start_user),
        .dout_leaf_interface2user (dout_leaf_interface2user),
        .vld_interface2user       (vld_interface2user),
        .ack_user2interface       (ack_user2interface),
        .din_leaf_user2interface  (din_leaf_user2interface),
        .vld_user2interface       (vld_user2interface),
        .ack_interface2user       (ack_interface2user)
    );

endmodule

`default_nettype wire

// ==== hw/leaf_interface/leaf_interface.sv ====
`default_nettype none
`include "leaf_macros.svh"

module leaf_interface
    import leaf_pkt_pkg::*, leaf_cfg_pkg::*;
(
    input  wire                                     clk_400,
    input  wire                                     arst_n,
    input  wire leaf_packet_t                       din_leaf_bft2interface,
    output wire leaf_packet_t                       dout_leaf_interface2bft,
    input  wire                                     resend,
    input  wire                                     ap_start,

    output wire payload_t [`LEAF_NUM_IN_PORTS-1:0]  dout_leaf_interface2user,
    output wire [`LEAF_NUM_IN_PORTS-1:0]            vld_interface2user,
    input  wire [`LEAF_NUM_IN_PORTS-1:0]            ack_user2interface,

    input  wire payload_t [`LEAF_NUM_OUT_PORTS-1:0] din_leaf_user2interface,
    input  wire [`LEAF_NUM_OUT_PORTS-1:0]           vld_user2interface,
    output logic [`LEAF_NUM_OUT_PORTS-1:0]          ack_interface2user,

    output logic                                    reset_ap_start_user
);

    logic [`LEAF_NUM_IN_PORTS-1:0]          port_wr;
    wire  [`LEAF_NUM_IN_PORTS-1:0]          port_full;
    payload_t                               port_data;
    logic                                   cfg_wr;
    cfg_word_t                              cfg_data;
    route_table_t                           route;
    logic                                   started;
    wire  [`LEAF_NUM_OUT_PORTS-1:0]         out_full;
    wire  [`LEAF_NUM_OUT_PORTS-1:0]         out_vld;
    wire  payload_t [`LEAF_NUM_OUT_PORTS-1:0] out_data;
    logic [`LEAF_NUM_OUT_PORTS-1:0]         out_ack;

    packet_dispatch dispatch_inst (
        .clk_400   (clk_400),
        .arst_n    (arst_n),
        .pkt       (din_leaf_bft2interface),
        .port_full (port_full),
        .port_wr   (port_wr),
        .port_data (port_data),
        .cfg_wr    (cfg_wr),
        .cfg_data  (cfg_data)
    );

    for (genvar i = 0; i < `LEAF_NUM_IN_PORTS; i++) begin : g_in_fifo
        stream_fifo #(
            .item_t (payload_t),
            .DEPTH  (`LEAF_FIFO_DEPTH)
        ) fifo_inst (
            .clk_400 (clk_400),
            .arst_n  (arst_n),
            .wr      (port_wr[i]),
            .wr_data (port_data),
            .full    (port_full[i]),
            .rd_vld  (vld_interface2user[i]),
            .rd_data (dout_leaf_interface2user[i]),
            .rd_ack  (ack_user2interface[i])
        );
    end

    // kernel results queue here, a full queue stalls the kernel
    for (genvar j = 0; j < `LEAF_NUM_OUT_PORTS; j++) begin : g_out_fifo
        stream_fifo #(
            .item_t (payload_t),
            .DEPTH  (`LEAF_FIFO_DEPTH)
        ) fifo_inst (
            .clk_400 (clk_400),
            .arst_n  (arst_n),
            .wr      (vld_user2interface[j]),
            .wr_data (din_leaf_user2interface[j]),
            .full    (out_full[j]),
            .rd_vld  (out_vld[j]),
            .rd_data (out_data[j]),
            .rd_ack  (out_ack[j])
        );
    end

    assign ack_interface2user = ~out_full;

    packet_builder builder_inst (
        .clk_400 (clk_400),
        .arst_n  (arst_n),
        .resend  (resend),
        .route   (route),
        .in_vld  (out_vld),
        .in_data (out_data),
        .in_ack  (out_ack),
        .pkt     (dout_leaf_interface2bft)
    );

    always_ff @(posedge clk_400 or negedge arst_n) begin
        if (!arst_n) begin
            route <= '0;
        end else if (cfg_wr) begin
            route[cfg_data.out_sel] <= cfg_route(cfg_data);
        end
    end

    // sticky, stays set until the next arst_n
    always_ff @(posedge clk_400 or negedge arst_n) begin
        if (!arst_n) begin
            started <= 1'b0;
        end else if (ap_start) begin
            started <= 1'b1;
        end
    end

    // low holds the kernel in reset
    assign reset_ap_start_user = arst_n && started;

endmodule

`default_nettype wire

// ==== hw/leaf_interface/packet_builder.sv ====
`default_nettype none
`include "leaf_macros.svh"

module packet_builder
    import leaf_pkt_pkg::*, leaf_cfg_pkg::*;
(
    input  wire                                     clk_400,
    input  wire                                     arst_n,
    input  wire                                     resend,
    input  wire route_table_t                       route,
    input  wire [`LEAF_NUM_OUT_PORTS-1:0]           in_vld,
    input  wire payload_t [`LEAF_NUM_OUT_PORTS-1:0] in_data,
    output logic [`LEAF_NUM_OUT_PORTS-1:0]          in_ack,
    output leaf_packet_t                            pkt
);

    // lane with priority next, 0 is output 1
    logic         rr;
    logic         sel;
    logic         take;
    src_port_t    src_port;
    leaf_packet_t pkt_q;

    always_comb begin
        sel = rr;
        if (!in_vld[rr]) begin
            sel = ~rr;
        end
        take        = !resend && (|in_vld);
        in_ack      = '0;
        in_ack[sel] = take;
        // source port numbers outputs from 1
        src_port    = src_port_t'(sel) + 1'b1;
    end

    always_ff @(posedge clk_400 or negedge arst_n) begin
        if (!arst_n) begin
            rr    <= 1'b0;
            pkt_q <= '0;
        end else if (!resend) begin
            if (take) begin
                pkt_q <= make_packet(route[sel].dest_leaf, route[sel].dest_port,
                                     `LEAF_SELF_ADDR, src_port, in_data[sel]);
                rr    <= ~sel;
            end else begin
                pkt_q <= '0;
            end
        end
    end

    // a packet built just before resend rose is held back until it falls
    assign pkt = resend ? '0 : pkt_q;

endmodule

`default_nettype wire

// ==== hw/leaf_interface/packet_dispatch.sv ====
`default_nettype none
`include "leaf_macros.svh"

module packet_dispatch
    import leaf_pkt_pkg::*, leaf_cfg_pkg::*;
(
    input  wire                            clk_400,
    input  wire                            arst_n,
    input  wire leaf_packet_t              pkt,
    input  wire [`LEAF_NUM_IN_PORTS-1:0]   port_full,
    output logic [`LEAF_NUM_IN_PORTS-1:0]  port_wr,
    output payload_t                       port_data,
    output logic                           cfg_wr,
    output cfg_word_t                      cfg_data
);

    logic                          for_self;
    logic                          cfg_hit;
    logic [`LEAF_NUM_IN_PORTS-1:0] port_hit;

    always_comb begin
        for_self = pkt_for_leaf(pkt, `LEAF_SELF_ADDR);
        cfg_hit  = for_self && (pkt.dest_port == '0);
        // ports 1 to 5 land on lanes 0 to 4, higher ports match nothing
        for (int i = 0; i < `LEAF_NUM_IN_PORTS; i++) begin
            port_hit[i] = for_self && (pkt.dest_port == port_addr_t'(i + 1));
        end
    end

    always_ff @(posedge clk_400 or negedge arst_n) begin
        if (!arst_n) begin
            port_wr <= '0;
            cfg_wr  <= 1'b0;
        end else begin
            // no room on the lane, packet is lost
            port_wr <= port_hit & ~port_full;
            cfg_wr  <= cfg_hit;
        end
    end

    // one payload register feeds every lane and the route table
    always_ff @(posedge clk_400) begin
        port_data <= pkt.payload;
        cfg_data  <= cfg_word_t'(pkt.payload);
    end

endmodule

`default_nettype wire

// ==== hw/leaf_interface/stream_fifo.sv ====
`default_nettype none
`include "leaf_macros.svh"

module stream_fifo #(
    parameter type item_t = logic [`LEAF_PAYLOAD_BITS-1:0],
    parameter int  DEPTH  = `LEAF_FIFO_DEPTH
) (
    input  wire        clk_400,
    input  wire        arst_n,
    input  wire        wr,
    input  wire item_t wr_data,
    output logic       full,
    output logic       rd_vld,
    output item_t      rd_data,
    input  wire        rd_ack
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = AW + 1;
    localparam logic [AW-1:0] LAST_IDX  = AW'(DEPTH - 1);
    localparam logic [CW-1:0] FULL_CNT  = CW'(DEPTH);

    item_t          mem [DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic [CW-1:0]  count;
    logic           push;
    logic           pop;

    assign full    = (count == FULL_CNT);
    assign rd_vld  = (count != '0);
    assign rd_data = mem[rd_ptr];

    // writes into a full buffer are ignored
    assign push = wr && !full;
    assign pop  = rd_vld && rd_ack;

    always_ff @(posedge clk_400) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk_400 or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_IDX) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/leaf_user/user_kernel.sv ====
`default_nettype none
`include "leaf_macros.svh"

module user_kernel
    import leaf_pkt_pkg::*;
(
    input  wire                                     clk_400,
    input  wire                                     reset_ap_start_user,
    input  wire payload_t [`LEAF_NUM_IN_PORTS-1:0]  dout_leaf_interface2user,
    input  wire [`LEAF_NUM_IN_PORTS-1:0]            vld_interface2user,
    output logic [`LEAF_NUM_IN_PORTS-1:0]           ack_user2interface,
    output payload_t [`LEAF_NUM_OUT_PORTS-1:0]      din_leaf_user2interface,
    output logic [`LEAF_NUM_OUT_PORTS-1:0]          vld_user2interface,
    input  wire [`LEAF_NUM_OUT_PORTS-1:0]           ack_interface2user
);

    logic running;
    logic sum_free;
    logic xor_free;
    logic fire_sum;
    logic fire_xor;

    // stays idle until the first clock after reset is released
    always_ff @(posedge clk_400 or negedge reset_ap_start_user) begin
        if (!reset_ap_start_user) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    // a result slot is free when empty or drained this cycle
    assign sum_free = !vld_user2interface[0] || ack_interface2user[0];
    assign xor_free = !vld_user2interface[1] || ack_interface2user[1];

    assign fire_sum = running && sum_free && vld_interface2user[0] && vld_interface2user[1];
    assign fire_xor = running && xor_free && (&vld_interface2user[4:2]);

    assign ack_user2interface = {fire_xor, fire_xor, fire_xor, fire_sum, fire_sum};

    always_ff @(posedge clk_400 or negedge reset_ap_start_user) begin
        if (!reset_ap_start_user) begin
            vld_user2interface <= '0;
        end else begin
            if (fire_sum) begin
                vld_user2interface[0] <= 1'b1;
            end else if (ack_interface2user[0]) begin
                vld_user2interface[0] <= 1'b0;
            end
            if (fire_xor) begin
                vld_user2interface[1] <= 1'b1;
            end else if (ack_interface2user[1]) begin
                vld_user2interface[1] <= 1'b0;
            end
        end
    end

    // sum wraps at 32 bits
    always_ff @(posedge clk_400) begin
        if (fire_sum) begin
            din_leaf_user2interface[0] <= dout_leaf_interface2user[0] +
                                          dout_leaf_interface2user[1];
        end
        if (fire_xor) begin
            din_leaf_user2interface[1] <= dout_leaf_interface2user[2] ^
                                          dout_leaf_interface2user[3] ^
                                          dout_leaf_interface2user[4];
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_leaf_i5o2.sv ====
`default_nettype none
`include "leaf_macros.svh"

module tb_leaf_i5o2
    import leaf_pkt_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] SEED = 32'h65f5_1b33;
    // about 150 packets at about 10 cycles each plus margin
    localparam int MAX_CYCLES = 4000;

    logic         clk_400;
    logic         arst_n;
    leaf_packet_t din_leaf_bft2interface;
    leaf_packet_t dout_leaf_interface2bft;
    logic         resend;
    logic         ap_start;

    payload_t     exp_sum_q[$];
    payload_t     exp_xor_q[$];
    leaf_packet_t rx_q[$];
    leaf_addr_t   route_leaf[2];
    port_addr_t   route_port[2];
    int           errors;
    int           tests_run;
    int           tests_failed;
    int           cycle_count;

    leaf_i5o2 leaf_i5o2_inst (
        .clk_400                 (clk_400),
        .arst_n                  (arst_n),
        .din_leaf_bft2interface  (din_leaf_bft2interface),
        .dout_leaf_interface2bft (dout_leaf_interface2bft),
        .resend                  (resend),
        .ap_start                (ap_start)
    );

    always #10 clk_400 = ~clk_400;

    always @(posedge clk_400) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == MAX_CYCLES) begin
            $display("run stopped after %0d cycles, results still missing", MAX_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // sampled mid-cycle away from the driving edge
    always @(negedge clk_400) begin
        if (resend && dout_leaf_interface2bft != '0) begin
            report_error("network output not zero while resend is high");
        end
        if (dout_leaf_interface2bft.valid) begin
            rx_q.push_back(dout_leaf_interface2bft);
        end
    end

    task automatic report_error(input string msg);
        $display("ERROR @ %0d ns: %s", $time, msg);
        errors++;
    endtask

    task automatic finish_test(input string name, input int start_errors);
        tests_run++;
        if (errors == start_errors) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - start_errors);
        end
    endtask

    task automatic send_pkt(input leaf_addr_t leaf, input port_addr_t port,
                            input payload_t data);
        leaf_packet_t pkt;
        pkt           = '0;
        pkt.valid     = 1'b1;
        pkt.dest_leaf = leaf;
        pkt.dest_port = port;
        pkt.src_leaf  = 5'd1;
        pkt.payload   = data;
        @(posedge clk_400);
        din_leaf_bft2interface <= pkt;
    endtask

    task automatic drive_idle();
        @(posedge clk_400);
        din_leaf_bft2interface <= '0;
    endtask

    task automatic apply_reset();
        @(posedge clk_400);
        arst_n                 <= 1'b0;
        din_leaf_bft2interface <= '0;
        resend                 <= 1'b0;
        ap_start               <= 1'b0;
        repeat (5) @(posedge clk_400);
        arst_n <= 1'b1;
    endtask

    task automatic pulse_start();
        @(posedge clk_400);
        ap_start <= 1'b1;
        @(posedge clk_400);
        ap_start <= 1'b0;
    endtask

    // cfg word has out select in bit 0, dest leaf in 12:8 and dest port in 19:16
    task automatic configure_route(input int lane, input leaf_addr_t leaf,
                                   input port_addr_t port);
        payload_t word;
        word        = '0;
        word[0]     = (lane == 1);
        word[12:8]  = leaf;
        word[19:16] = port;
        send_pkt(`LEAF_SELF_ADDR, 4'd0, word);
        drive_idle();
        route_leaf[lane] = leaf;
        route_port[lane] = port;
    endtask

    task automatic send_pair(input bit keep);
        payload_t a;
        payload_t b;
        payload_t sum;
        a   = $urandom();
        b   = $urandom();
        sum = a + b;
        send_pkt(`LEAF_SELF_ADDR, 4'd1, a);
        send_pkt(`LEAF_SELF_ADDR, 4'd2, b);
        if (keep) begin
            exp_sum_q.push_back(sum);
        end
    endtask

    task automatic send_triple();
        payload_t a;
        payload_t b;
        payload_t c;
        a = $urandom();
        b = $urandom();
        c = $urandom();
        send_pkt(`LEAF_SELF_ADDR, 4'd3, a);
        send_pkt(`LEAF_SELF_ADDR, 4'd4, b);
        send_pkt(`LEAF_SELF_ADDR, 4'd5, c);
        exp_xor_q.push_back(a ^ b ^ c);
    endtask

    task automatic compare_packet(input leaf_packet_t pkt, input int lane,
                                  input payload_t exp);
        if (pkt.dest_leaf != route_leaf[lane]) begin
            report_error($sformatf("out %0d dest_leaf %0d, expected %0d",
                                   lane + 1, pkt.dest_leaf, route_leaf[lane]));
        end
        if (pkt.dest_port != route_port[lane]) begin
            report_error($sformatf("out %0d dest_port %0d, expected %0d",
                                   lane + 1, pkt.dest_port, route_port[lane]));
        end
        if (pkt.src_leaf != `LEAF_SELF_ADDR) begin
            report_error($sformatf("out %0d src_leaf %0d, expected %0d",
                                   lane + 1, pkt.src_leaf, `LEAF_SELF_ADDR));
        end
        if (pkt.payload != exp) begin
            report_error($sformatf("out %0d payload %08h, expected %08h",
                                   lane + 1, pkt.payload, exp));
        end
    endtask

    // waits for every expected result and then a quiet spell to catch extras
    task automatic wait_results();
        leaf_packet_t pkt;
        int           expected;
        expected = exp_sum_q.size() + exp_xor_q.size();
        while (rx_q.size() < expected) begin
            @(posedge clk_400);
        end
        repeat (20) @(posedge clk_400);
        while (rx_q.size() > 0) begin
            pkt = rx_q.pop_front();
            if (pkt.src_port == 2'd1 && exp_sum_q.size() > 0) begin
                compare_packet(pkt, 0, exp_sum_q.pop_front());
            end else if (pkt.src_port == 2'd2 && exp_xor_q.size() > 0) begin
                compare_packet(pkt, 1, exp_xor_q.pop_front());
            end else begin
                $display("unexpected packet from output port %0d, payload %08h",
                         pkt.src_port, pkt.payload);
                errors++;
            end
        end
        if (exp_sum_q.size() + exp_xor_q.size() != 0) begin
            $display("%0d results never arrived", exp_sum_q.size() + exp_xor_q.size());
            errors++;
        end
        exp_sum_q.delete();
        exp_xor_q.delete();
    endtask

    task automatic test_reset_state();
        int start_errors;
        start_errors = errors;
        repeat (20) begin
            @(negedge clk_400);
            if (dout_leaf_interface2bft != '0) begin
                report_error("network output not zero after reset");
            end
        end
        finish_test("reset_state", start_errors);
    endtask

    task automatic test_sum_route();
        int start_errors;
        start_errors = errors;
        configure_route(0, 5'd9, 4'd4);
        pulse_start();
        repeat (10) send_pair(1'b1);
        drive_idle();
        wait_results();
        finish_test("sum_route", start_errors);
    endtask

    task automatic test_xor_round_robin();
        int start_errors;
        start_errors = errors;
        configure_route(1, 5'd17, 4'd2);
        repeat (10) begin
            send_triple();
            send_pair(1'b1);
        end
        drive_idle();
        wait_results();
        finish_test("xor_round_robin", start_errors);
    endtask

    task automatic test_filtering();
        int start_errors;
        start_errors = errors;
        for (int p = 6; p < 16; p++) begin
            send_pkt(`LEAF_SELF_ADDR, port_addr_t'(p), payload_t'($urandom()));
        end
        send_pkt(5'd7, 4'd1, payload_t'($urandom()));
        send_pkt(5'd0, 4'd3, payload_t'($urandom()));
        send_pkt(5'd31, 4'd2, payload_t'($urandom()));
        repeat (2) begin
            send_pair(1'b1);
            send_triple();
            send_pair(1'b1);
        end
        drive_idle();
        wait_results();
        finish_test("filtering", start_errors);
    endtask

    task automatic test_overflow_drop();
        int start_errors;
        start_errors = errors;
        apply_reset();
        configure_route(0, 5'd9, 4'd4);
        // kernel idle so lanes 1 and 2 fill up and the rest is lost
        for (int i = 0; i < 12; i++) begin
            send_pair(i < `LEAF_FIFO_DEPTH);
        end
        drive_idle();
        repeat (5) @(posedge clk_400);
        pulse_start();
        wait_results();
        finish_test("overflow_drop", start_errors);
    endtask

    task automatic test_resend();
        int start_errors;
        start_errors = errors;
        configure_route(0, 5'd12, 4'd9);
        configure_route(1, 5'd20, 4'd7);
        @(posedge clk_400);
        resend <= 1'b1;
        repeat (5) begin
            send_pair(1'b1);
            send_triple();
        end
        drive_idle();
        repeat (4) @(posedge clk_400);
        if (rx_q.size() != 0) begin
            report_error($sformatf("%0d packets left during resend", rx_q.size()));
        end
        resend <= 1'b0;
        wait_results();
        finish_test("resend", start_errors);
    endtask

    initial begin
        void'($urandom(SEED));
        clk_400                = 1'b0;
        arst_n                 = 1'b0;
        din_leaf_bft2interface = '0;
        resend                 = 1'b0;
        ap_start               = 1'b0;
        errors                 = 0;
        tests_run              = 0;
        tests_failed           = 0;
        cycle_count            = 0;
        repeat (5) @(posedge clk_400);
        arst_n <= 1'b1;

        test_reset_state();
        test_sum_route();
        test_xor_round_robin();
        test_filtering();
        test_overflow_drop();
        test_resend();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
